/* Makefile */
TOP      ?= ooo_backend_tb
FILES    ?= all.f
VERILATOR ?= verilator
VFLAGS   ?= --timing --assert
OBJ_DIR  ?= obj_dir
PASS_MSG := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILES)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILES))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILES)

# fails unless the pass message shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
ooo_pkg.sv
rename_stage.sv
reorder_buffer.sv
retire_stage.sv
ooo_backend_top.sv
tb_clock_gen.sv
ooo_backend_tb.sv

/* ooo_backend_tb.sv */
`timescale 1ns/10ps

module ooo_backend_tb;
    import ooo_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS   = 18;
    localparam int NUM_TESTS  = 6;
    localparam int STALL_TEST = 5;

    typedef struct packed {
        logic                  valid;
        op_class_t             op;
        logic                  wr;
        logic [ARCH_WIDTH-1:0] rd;
        logic [ADDR_WIDTH-1:0] pc;
        logic [STORE_ID_WIDTH-1:0] sid;
        logic                  mis;
        logic                  taken;
        logic [ADDR_WIDTH-1:0] tgt;
    } slot_t;

    typedef struct packed {
        logic [ROB_WIDTH-1:0]      id;
        op_class_t                 op;
        logic [STORE_ID_WIDTH-1:0] sid;
        branch_info_t              bi;
    } comp_t;

    typedef struct packed {
        logic [ROB_WIDTH-1:0] id;
        logic [PHY_WIDTH-1:0] phy;
    } iss_t;

    logic clk;
    logic rst;
    rename_req_t req_0;
    rename_req_t req_1;
    logic alu_valid;
    logic [ROB_WIDTH-1:0] alu_rob_id;
    logic load_valid;
    logic [ROB_WIDTH-1:0] load_rob_id;
    logic store_valid;
    logic [ROB_WIDTH-1:0] store_rob_id;
    logic [STORE_ID_WIDTH-1:0] store_id;
    logic branch_valid;
    logic [ROB_WIDTH-1:0] branch_rob_id;
    branch_info_t branch_info;
    logic stall;
    logic [1:0] issue_valid;
    logic [ROB_WIDTH-1:0] issue_rob_id_0;
    logic [ROB_WIDTH-1:0] issue_rob_id_1;
    logic [PHY_WIDTH-1:0] issue_phy_0;
    logic [PHY_WIDTH-1:0] issue_phy_1;
    logic retire_valid;
    retire_t retire;
    logic redirect_valid;
    logic [ADDR_WIDTH-1:0] redirect_pc;

    // stimulus table
    int    row_test [NUM_ROWS];
    slot_t row_s0 [NUM_ROWS];
    slot_t row_s1 [NUM_ROWS];
    string test_name [NUM_TESTS];
    int    row_cnt;

    // reference model state
    logic [PHY_WIDTH-1:0] m_spec [NUM_ARCH];
    logic [PHY_WIDTH-1:0] m_commit [NUM_ARCH];
    logic [31:0]          m_free;
    logic [31:0]          m_busy;
    logic [ROB_WIDTH-1:0] m_tail;
    retire_t ret_q [$];
    iss_t    iss_q [$];
    comp_t   comp_q [$];
    logic [31:0] seed;
    int checks;
    int errors;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(4)) clock_gen_inst (.clk(clk), .rst(rst));

    ooo_backend_top #(.NUM_ROB_ENTRY(16), .NUM_PHY(32)) ooo_backend_top_inst (
        .clk(clk), .rst(rst), .req_0(req_0), .req_1(req_1),
        .alu_valid(alu_valid), .alu_rob_id(alu_rob_id),
        .load_valid(load_valid), .load_rob_id(load_rob_id),
        .store_valid(store_valid), .store_rob_id(store_rob_id), .store_id(store_id),
        .branch_valid(branch_valid), .branch_rob_id(branch_rob_id),
        .branch_info(branch_info),
        .stall(stall), .issue_valid(issue_valid),
        .issue_rob_id_0(issue_rob_id_0), .issue_rob_id_1(issue_rob_id_1),
        .issue_phy_0(issue_phy_0), .issue_phy_1(issue_phy_1),
        .retire_valid(retire_valid), .retire(retire),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    function automatic slot_t ins(input logic v, input op_class_t op, input logic wr,
                                  input int rd, input int pc, input int sid,
                                  input logic mis, input logic taken, input int tgt);
        return '{v, op, wr, 3'(rd), 16'(pc), 3'(sid), mis, taken, 16'(tgt)};
    endfunction

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic rename_req_t to_req(input slot_t s);
        return '{valid: s.valid, op_class: s.op, writes_rd: s.wr, rd_arch: s.rd, pc: s.pc};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH time=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input int t, input slot_t s0, input slot_t s1);
        row_test[row_cnt] = t;
        row_s0[row_cnt]   = s0;
        row_s1[row_cnt]   = s1;
        row_cnt++;
    endtask

    task automatic fill_table();
        row_cnt = 0;
        // order and rename with a slot 1 dependency on slot 0
        add_row(0, ins(1, OP_ALU, 1, 1, 'h100, 0, 0, 0, 0),
                ins(1, OP_LOAD, 1, 1, 'h104, 0, 0, 0, 0));
        add_row(0, ins(1, OP_ALU, 1, 2, 'h108, 0, 0, 0, 0),
                ins(1, OP_STORE, 0, 0, 'h10c, 5, 0, 0, 0));
        add_row(0, ins(1, OP_LOAD, 1, 3, 'h110, 0, 0, 0, 0),
                ins(1, OP_ALU, 1, 2, 'h114, 0, 0, 0, 0));
        // reclaim
        add_row(1, ins(1, OP_ALU, 1, 1, 'h200, 0, 0, 0, 0),
                ins(1, OP_ALU, 1, 4, 'h204, 0, 0, 0, 0));
        add_row(1, ins(1, OP_LOAD, 1, 5, 'h208, 0, 0, 0, 0),
                ins(1, OP_ALU, 1, 1, 'h20c, 0, 0, 0, 0));
        // store and branch payload
        add_row(2, ins(1, OP_STORE, 0, 0, 'h300, 3, 0, 0, 0),
                ins(1, OP_BRANCH, 0, 0, 'h304, 0, 0, 1, 'h400));
        add_row(2, ins(1, OP_STORE, 0, 0, 'h308, 6, 0, 0, 0),
                ins(1, OP_ALU, 1, 6, 'h30c, 0, 0, 0, 0));
        // mispredict where the younger pair must vanish
        add_row(3, ins(1, OP_ALU, 1, 7, 'h500, 0, 0, 0, 0),
                ins(1, OP_BRANCH, 0, 0, 'h504, 0, 1, 1, 'h800));
        add_row(3, ins(1, OP_ALU, 1, 1, 'h508, 0, 0, 0, 0),
                ins(1, OP_LOAD, 1, 2, 'h50c, 0, 0, 0, 0));
        add_row(4, ins(1, OP_ALU, 1, 1, 'h800, 0, 0, 0, 0),
                ins(1, OP_ALU, 1, 3, 'h804, 0, 0, 0, 0));
        add_row(4, ins(1, OP_LOAD, 1, 1, 'h808, 0, 0, 0, 0),
                ins(0, OP_ALU, 0, 0, 0, 0, 0, 0, 0));
        // 14 in flight fills the rob
        for (int k = 0; k < 7; k++) begin
            add_row(STALL_TEST, ins(1, OP_ALU, 1, k, 'h900 + 8 * k, 0, 0, 0, 0),
                    ins(1, OP_LOAD, 1, 7 - k, 'h904 + 8 * k, 0, 0, 0, 0));
        end
        test_name = '{"retire order", "register reclaim", "store and branch payload",
                      "mispredict flush", "rename after flush", "stall"};
    endtask

    // model of rename for one accepted slot
    task automatic rename_model(input slot_t s, inout logic squash);
        retire_t e;
        int p;
        e = '0;
        p = -1;
        e.op_class  = s.op;
        e.writes_rd = s.wr;
        e.rd_arch   = s.rd;
        e.pc        = s.pc;
        e.rob_id    = m_tail;
        if (s.wr) begin
            for (int k = 0; k < 32; k++) begin
                if (m_free[k] && p < 0) begin
                    p = k;
                end
            end
            e.rd_phy_old = m_spec[s.rd];
            e.rd_phy_new = 5'(p);
            m_free[p]    = 1'b0;
            m_spec[s.rd] = 5'(p);
        end
        if (s.op == OP_STORE) begin
            e.payload.store.store_id = s.sid;
        end
        if (s.op == OP_BRANCH) begin
            e.payload.branch = '{s.mis, s.taken, s.tgt};
        end
        iss_q.push_back('{m_tail, e.rd_phy_new});
        comp_q.push_back('{m_tail, s.op, s.sid, '{s.mis, s.taken, s.tgt}});
        if (!squash) begin
            ret_q.push_back(e);
        end
        if (s.op == OP_BRANCH && s.mis) begin
            squash = 1'b1;
        end
        m_tail = m_tail + 1'b1;
    endtask

    task automatic clear_completion();
        alu_valid    = 1'b0;
        load_valid   = 1'b0;
        store_valid  = 1'b0;
        branch_valid = 1'b0;
    endtask

    task automatic drive_completion(input comp_t c);
        clear_completion();
        case (c.op)
            OP_ALU: begin
                alu_valid  = 1'b1;
                alu_rob_id = c.id;
            end
            OP_LOAD: begin
                load_valid  = 1'b1;
                load_rob_id = c.id;
            end
            OP_STORE: begin
                store_valid  = 1'b1;
                store_rob_id = c.id;
                store_id     = c.sid;
            end
            default: begin
                branch_valid  = 1'b1;
                branch_rob_id = c.id;
                branch_info   = c.bi;
            end
        endcase
    endtask

    task automatic shuffle_completions(input logic squash);
        comp_t tmp;
        int j;
        int mis_idx;
        mis_idx = -1;
        for (int i = comp_q.size() - 1; i > 0; i--) begin
            j = int'(lcg_next() % 32'(i + 1));
            tmp = comp_q[i];
            comp_q[i] = comp_q[j];
            comp_q[j] = tmp;
        end
        // the mispredicted branch completes last so no id is completed after flush
        if (squash) begin
            foreach (comp_q[i]) begin
                if (comp_q[i].op == OP_BRANCH && comp_q[i].bi.mispredict) begin
                    mis_idx = i;
                end
            end
            tmp = comp_q[mis_idx];
            comp_q.delete(mis_idx);
            comp_q.push_back(tmp);
        end
    endtask

    task automatic compare_issue(input logic [ROB_WIDTH-1:0] id, input logic [PHY_WIDTH-1:0] phy);
        iss_t x;
        if (iss_q.size() == 0) begin
            errors++;
            $display("unexpected issue of rob id %0d at time %0t", id, $time);
        end else begin
            x = iss_q.pop_front();
            check("issue_rob_id", 32'(id), 32'(x.id));
            check("issue_phy", 32'(phy), 32'(x.phy));
        end
    endtask

    always @(negedge clk) begin
        if (!rst && issue_valid[0]) begin
            compare_issue(issue_rob_id_0, issue_phy_0);
        end
        if (!rst && issue_valid[1]) begin
            compare_issue(issue_rob_id_1, issue_phy_1);
        end
    end

    always @(negedge clk) begin : retire_monitor
        retire_t e;
        logic mis;
        if (!rst && retire_valid) begin
            if (ret_q.size() == 0) begin
                errors++;
                $display("unexpected retire of rob id %0d at time %0t", retire.rob_id, $time);
            end else begin
                e = ret_q.pop_front();
                mis = (e.op_class == OP_BRANCH) && e.payload.branch.mispredict;
                check("retire.rob_id", 32'(retire.rob_id), 32'(e.rob_id));
                check("retire.pc", 32'(retire.pc), 32'(e.pc));
                check("retire.op_class", 32'(retire.op_class), 32'(e.op_class));
                check("retire.writes_rd", 32'(retire.writes_rd), 32'(e.writes_rd));
                check("retire.rd_arch", 32'(retire.rd_arch), 32'(e.rd_arch));
                check("retire.rd_phy_new", 32'(retire.rd_phy_new), 32'(e.rd_phy_new));
                check("retire.rd_phy_old", 32'(retire.rd_phy_old), 32'(e.rd_phy_old));
                check("retire.payload", 32'(retire.payload), 32'(e.payload));
                check("redirect_valid", 32'(redirect_valid), 32'(mis));
                if (e.writes_rd) begin
                    m_commit[e.rd_arch]  = e.rd_phy_new;
                    m_busy[e.rd_phy_old] = 1'b0;
                    m_busy[e.rd_phy_new] = 1'b1;
                    m_free[e.rd_phy_old] = 1'b1;
                end
                if (mis) begin
                    check("redirect_pc", 32'(redirect_pc), 32'(e.payload.branch.actual_target));
                    m_spec = m_commit;
                    m_free = ~m_busy;
                    m_tail = '0;
                end
            end
        end
    end

    initial begin
        #(NUM_ROWS * 40 * CLK_PERIOD);
        $display("timeout: the run did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        logic squash;
        int err_before;
        req_0 = '0;
        req_1 = '0;
        alu_rob_id = '0;
        load_rob_id = '0;
        store_rob_id = '0;
        branch_rob_id = '0;
        store_id = '0;
        branch_info = '0;
        clear_completion();
        seed = 32'hd9f0;
        checks = 0;
        errors = 0;
        for (int r = 0; r < NUM_ARCH; r++) begin
            m_spec[r]   = 5'(r);
            m_commit[r] = 5'(r);
        end
        m_free = 32'hffff_ff00;
        m_busy = 32'h0000_00ff;
        m_tail = '0;
        fill_table();
        @(negedge rst);
        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before = errors;
            squash = 1'b0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (row_test[r] == t) begin
                    @(negedge clk);
                    req_0 = to_req(row_s0[r]);
                    req_1 = to_req(row_s1[r]);
                    while (stall) @(negedge clk);
                    if (row_s0[r].valid) rename_model(row_s0[r], squash);
                    if (row_s1[r].valid) rename_model(row_s1[r], squash);
                end
            end
            @(negedge clk);
            req_0 = '0;
            req_1 = '0;
            if (t == STALL_TEST) begin
                check("stall", 32'(stall), 32'd1);
            end
            shuffle_completions(squash);
            foreach (comp_q[i]) begin
                @(negedge clk);
                drive_completion(comp_q[i]);
            end
            @(negedge clk);
            clear_completion();
            comp_q.delete();
            while (ret_q.size() != 0) @(negedge clk);
            repeat (4) @(negedge clk);
            if (iss_q.size() != 0) begin
                errors++;
                $display("%0d issued entries were never seen", iss_q.size());
                iss_q.delete();
            end
            $display("test %0d %s: %s", t, test_name[t], (errors == err_before) ? "ok" : "fail");
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* ooo_backend_top.sv */
`timescale 1ns/10ps

module ooo_backend_top #(
    parameter int NUM_ROB_ENTRY = 16,
    parameter int NUM_PHY       = 32
) (
    input  logic                               clk,
    input  logic                               rst,
    input  ooo_pkg::rename_req_t               req_0,
    input  ooo_pkg::rename_req_t               req_1,
    input  logic                               alu_valid,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]      alu_rob_id,
    input  logic                               load_valid,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]      load_rob_id,
    input  logic                               store_valid,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]      store_rob_id,
    input  logic [ooo_pkg::STORE_ID_WIDTH-1:0] store_id,
    input  logic                               branch_valid,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]      branch_rob_id,
    input  ooo_pkg::branch_info_t              branch_info,
    output logic                               stall,
    output logic [1:0]                         issue_valid,
    output logic [ooo_pkg::ROB_WIDTH-1:0]      issue_rob_id_0,
    output logic [ooo_pkg::ROB_WIDTH-1:0]      issue_rob_id_1,
    output logic [ooo_pkg::PHY_WIDTH-1:0]      issue_phy_0,
    output logic [ooo_pkg::PHY_WIDTH-1:0]      issue_phy_1,
    output logic                               retire_valid,
    output ooo_pkg::retire_t                   retire,
    output logic                               redirect_valid,
    output logic [ooo_pkg::ADDR_WIDTH-1:0]     redirect_pc
);
    import ooo_pkg::*;

    logic                 rob_full;
    logic                 flush;
    logic                 pop;
    logic [1:0]           dispatch_valid;
    rob_entry_t           dispatch_0;
    rob_entry_t           dispatch_1;
    rob_entry_t           head_entry;
    logic [ROB_WIDTH-1:0] head_id;

    rename_stage #(
        .NUM_PHY       (NUM_PHY),
        .NUM_ROB_ENTRY (NUM_ROB_ENTRY)
    ) rename_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .req_0          (req_0),
        .req_1          (req_1),
        .rob_full       (rob_full),
        .flush          (flush),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .stall          (stall),
        .dispatch_valid (dispatch_valid),
        .dispatch_0     (dispatch_0),
        .dispatch_1     (dispatch_1)
    );

    reorder_buffer #(
        .NUM_ROB_ENTRY (NUM_ROB_ENTRY)
    ) reorder_buffer_inst (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_0     (dispatch_0),
        .dispatch_1     (dispatch_1),
        .alu_valid      (alu_valid),
        .alu_rob_id     (alu_rob_id),
        .load_valid     (load_valid),
        .load_rob_id    (load_rob_id),
        .store_valid    (store_valid),
        .store_rob_id   (store_rob_id),
        .store_id       (store_id),
        .branch_valid   (branch_valid),
        .branch_rob_id  (branch_rob_id),
        .branch_info    (branch_info),
        .rob_id_0       (issue_rob_id_0),
        .rob_id_1       (issue_rob_id_1),
        .rob_full       (rob_full),
        .rob_empty      (),
        .pop            (pop),
        .head_id        (head_id),
        .head_entry     (head_entry)
    );

    retire_stage retire_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .pop            (pop),
        .head_id        (head_id),
        .head_entry     (head_entry),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // execution side learns ids and destinations as the pair enters the rob
    assign issue_valid = dispatch_valid;
    assign issue_phy_0 = dispatch_0.rd_phy_new;
    assign issue_phy_1 = dispatch_1.rd_phy_new;

endmodule

/* ooo_pkg.sv */
package ooo_pkg;

    localparam int ARCH_WIDTH     = 3;
    localparam int PHY_WIDTH      = 5;
    localparam int ROB_WIDTH      = 4;
    localparam int ADDR_WIDTH     = 16;
    localparam int STORE_ID_WIDTH = 3;

    localparam int NUM_ARCH      = 1 << ARCH_WIDTH;
    // both union views share this width
    localparam int PAYLOAD_WIDTH = ADDR_WIDTH + 2;

    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } op_class_t;

    // one decoded instruction at the rename input
    typedef struct packed {
        logic                  valid;
        op_class_t             op_class;
        logic                  writes_rd;
        logic [ARCH_WIDTH-1:0] rd_arch;
        logic [ADDR_WIDTH-1:0] pc;
    } rename_req_t;

    typedef struct packed {
        logic                  mispredict;
        logic                  actual_taken;
        logic [ADDR_WIDTH-1:0] actual_target;
    } branch_info_t;

    typedef struct packed {
        logic [PAYLOAD_WIDTH-STORE_ID_WIDTH-1:0] pad;
        logic [STORE_ID_WIDTH-1:0]               store_id;
    } store_info_t;

    // op_class picks the view
    typedef union packed {
        branch_info_t branch;
        store_info_t  store;
    } rob_payload_u;

    typedef struct packed {
        op_class_t             op_class;
        logic                  writes_rd;
        logic [ARCH_WIDTH-1:0] rd_arch;
        logic [PHY_WIDTH-1:0]  rd_phy_old;
        logic [PHY_WIDTH-1:0]  rd_phy_new;
        logic [ADDR_WIDTH-1:0] pc;
        rob_payload_u          payload;
    } rob_entry_t;

    typedef struct packed {
        op_class_t             op_class;
        logic                  writes_rd;
        logic [ARCH_WIDTH-1:0] rd_arch;
        logic [PHY_WIDTH-1:0]  rd_phy_new;
        logic [PHY_WIDTH-1:0]  rd_phy_old;
        logic [ADDR_WIDTH-1:0] pc;
        logic [ROB_WIDTH-1:0]  rob_id;
        rob_payload_u          payload;
    } retire_t;

endpackage

/* rename_stage.sv */
`timescale 1ns/10ps

module rename_stage #(
    parameter int NUM_PHY       = 32,
    parameter int NUM_ROB_ENTRY = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::rename_req_t req_0,
    input  ooo_pkg::rename_req_t req_1,
    input  logic                rob_full,
    input  logic                flush,
    input  logic                retire_valid,
    input  ooo_pkg::retire_t    retire,
    output logic                stall,
    output logic [1:0]          dispatch_valid,
    output ooo_pkg::rob_entry_t dispatch_0,
    output ooo_pkg::rob_entry_t dispatch_1
);
    import ooo_pkg::*;

    logic [PHY_WIDTH-1:0] spec_map [NUM_ARCH];
    logic [PHY_WIDTH-1:0] commit_map [NUM_ARCH];
    logic [PHY_WIDTH-1:0] commit_map_nxt [NUM_ARCH];
    logic [NUM_PHY-1:0]   free;
    logic [NUM_PHY-1:0]   free_nxt;
    logic [NUM_PHY-1:0]   commit_busy;
    logic [NUM_PHY-1:0]   commit_busy_nxt;
    logic [PHY_WIDTH-1:0] phy_a;
    logic [PHY_WIDTH-1:0] phy_b;
    logic                 found_a;
    logic                 found_b;
    logic                 accept;
    logic                 wr_0;
    logic                 wr_1;
    logic [PHY_WIDTH-1:0] phy_0;
    logic [PHY_WIDTH-1:0] phy_1;
    logic [PHY_WIDTH-1:0] old_1;

    // every rob entry must be able to hold a fresh register
    if (NUM_PHY < NUM_ARCH + NUM_ROB_ENTRY) begin : g_size_check
        $error("NUM_PHY too small for NUM_ROB_ENTRY");
    end

    // two lowest free registers
    always_comb begin
        found_a = 1'b0;
        found_b = 1'b0;
        phy_a   = '0;
        phy_b   = '0;
        for (int p = 0; p < NUM_PHY; p++) begin
            if (free[p] && found_a && !found_b) begin
                phy_b   = PHY_WIDTH'(p);
                found_b = 1'b1;
            end
            if (free[p] && !found_a) begin
                phy_a   = PHY_WIDTH'(p);
                found_a = 1'b1;
            end
        end
    end

    assign stall  = rob_full | ~found_b | flush;
    assign accept = ~stall;
    assign wr_0   = accept & req_0.valid & req_0.writes_rd;
    assign wr_1   = accept & req_1.valid & req_1.writes_rd;
    assign phy_0  = phy_a;
    assign phy_1  = wr_0 ? phy_b : phy_a;
    // slot 1 sees slot 0's new mapping
    assign old_1  = (wr_0 && req_0.rd_arch == req_1.rd_arch) ? phy_0 : spec_map[req_1.rd_arch];

    always_comb begin
        commit_map_nxt  = commit_map;
        commit_busy_nxt = commit_busy;
        free_nxt        = free;
        if (wr_0) begin
            free_nxt[phy_0] = 1'b0;
        end
        if (wr_1) begin
            free_nxt[phy_1] = 1'b0;
        end
        if (retire_valid && retire.writes_rd) begin
            commit_map_nxt[retire.rd_arch]  = retire.rd_phy_new;
            commit_busy_nxt[retire.rd_phy_old] = 1'b0;
            commit_busy_nxt[retire.rd_phy_new] = 1'b1;
            free_nxt[retire.rd_phy_old]     = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < NUM_ARCH; r++) begin
                spec_map[r]   <= PHY_WIDTH'(r);
                commit_map[r] <= PHY_WIDTH'(r);
            end
            free           <= {{(NUM_PHY-NUM_ARCH){1'b1}}, {NUM_ARCH{1'b0}}};
            commit_busy    <= {{(NUM_PHY-NUM_ARCH){1'b0}}, {NUM_ARCH{1'b1}}};
            dispatch_valid <= 2'b00;
        end else begin
            commit_map  <= commit_map_nxt;
            commit_busy <= commit_busy_nxt;
            if (flush) begin
                // back to the committed state
                spec_map       <= commit_map_nxt;
                free           <= ~commit_busy_nxt;
                dispatch_valid <= 2'b00;
            end else begin
                free <= free_nxt;
                if (wr_0) begin
                    spec_map[req_0.rd_arch] <= phy_0;
                end
                if (wr_1) begin
                    spec_map[req_1.rd_arch] <= phy_1;
                end
                dispatch_valid <= accept ? {req_1.valid, req_0.valid} : 2'b00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dispatch_0.op_class   <= req_0.op_class;
            dispatch_0.writes_rd  <= req_0.writes_rd;
            dispatch_0.rd_arch    <= req_0.rd_arch;
            dispatch_0.rd_phy_old <= req_0.writes_rd ? spec_map[req_0.rd_arch] : '0;
            dispatch_0.rd_phy_new <= req_0.writes_rd ? phy_0 : '0;
            dispatch_0.pc         <= req_0.pc;
            dispatch_0.payload    <= '0;
            dispatch_1.op_class   <= req_1.op_class;
            dispatch_1.writes_rd  <= req_1.writes_rd;
            dispatch_1.rd_arch    <= req_1.rd_arch;
            dispatch_1.rd_phy_old <= req_1.writes_rd ? old_1 : '0;
            dispatch_1.rd_phy_new <= req_1.writes_rd ? phy_1 : '0;
            dispatch_1.pc         <= req_1.pc;
            dispatch_1.payload    <= '0;
        end
    end

    // free list and committed busy set never overlap at allocation
    assert property (@(posedge clk) disable iff (rst)
        (wr_0 |-> !commit_busy[phy_0]) and (wr_1 |-> !commit_busy[phy_1]))
        else $error("allocated a committed physical register");

endmodule

/* reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer #(
    parameter int NUM_ROB_ENTRY = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flush,
    input  logic [1:0]                           dispatch_valid,
    input  ooo_pkg::rob_entry_t                  dispatch_0,
    input  ooo_pkg::rob_entry_t                  dispatch_1,
    input  logic                                 alu_valid,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]        alu_rob_id,
    input  logic                                 load_valid,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]        load_rob_id,
    input  logic                                 store_valid,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]        store_rob_id,
    input  logic [ooo_pkg::STORE_ID_WIDTH-1:0]   store_id,
    input  logic                                 branch_valid,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]        branch_rob_id,
    input  ooo_pkg::branch_info_t                branch_info,
    output logic [ooo_pkg::ROB_WIDTH-1:0]        rob_id_0,
    output logic [ooo_pkg::ROB_WIDTH-1:0]        rob_id_1,
    output logic                                 rob_full,
    output logic                                 rob_empty,
    output logic                                 pop,
    output logic [ooo_pkg::ROB_WIDTH-1:0]        head_id,
    output ooo_pkg::rob_entry_t                  head_entry
);
    import ooo_pkg::*;

    rob_entry_t               rob_mem [NUM_ROB_ENTRY];
    logic [NUM_ROB_ENTRY-1:0] finished;
    logic [ROB_WIDTH-1:0]     head;
    logic [ROB_WIDTH-1:0]     tail;
    logic [ROB_WIDTH-1:0]     slot_1;
    logic [ROB_WIDTH:0]       count;
    logic [ROB_WIDTH+1:0]     in_flight;
    logic [1:0]               n_disp;

    // pointers wrap on their own width
    if (NUM_ROB_ENTRY != (1 << ROB_WIDTH)) begin : g_depth_check
        $error("NUM_ROB_ENTRY must equal 2**ROB_WIDTH");
    end

    function automatic logic occupied(input logic [ROB_WIDTH-1:0] id);
        logic [ROB_WIDTH-1:0] offset;
        offset = id - head;
        return {1'b0, offset} < count;
    endfunction

    assign n_disp    = {1'b0, dispatch_valid[0]} + {1'b0, dispatch_valid[1]};
    assign slot_1    = dispatch_valid[0] ? tail + 1'b1 : tail;
    assign rob_id_0  = dispatch_valid[0] ? tail : '0;
    assign rob_id_1  = dispatch_valid[1] ? slot_1 : '0;
    // the pair entering this cycle already counts as in flight
    assign in_flight = {1'b0, count} + (ROB_WIDTH+2)'(n_disp);
    assign rob_full  = in_flight >= (ROB_WIDTH+2)'(NUM_ROB_ENTRY - 2);
    assign rob_empty = (count == '0);
    assign pop        = ~rob_empty & finished[head] & ~flush;
    assign head_id    = head;
    assign head_entry = rob_mem[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            finished <= '0;
        end else if (flush) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            finished <= '0;
        end else begin
            tail  <= tail + ROB_WIDTH'(n_disp);
            count <= count + (ROB_WIDTH+1)'(n_disp) - (ROB_WIDTH+1)'(pop);
            if (pop) begin
                finished[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            if (alu_valid) begin
                finished[alu_rob_id] <= 1'b1;
            end
            if (load_valid) begin
                finished[load_rob_id] <= 1'b1;
            end
            if (store_valid) begin
                finished[store_rob_id] <= 1'b1;
            end
            if (branch_valid) begin
                finished[branch_rob_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid[0]) begin
            rob_mem[tail] <= dispatch_0;
        end
        if (dispatch_valid[1]) begin
            rob_mem[slot_1] <= dispatch_1;
        end
        // completion fills the matching view of the payload
        if (store_valid) begin
            rob_mem[store_rob_id].payload.store.store_id <= store_id;
        end
        if (branch_valid) begin
            rob_mem[branch_rob_id].payload.branch <= branch_info;
        end
    end

    // rename must stall the cycle after full
    assert property (@(posedge clk) disable iff (rst) rob_full |=> dispatch_valid == 2'b00)
        else $error("dispatch into a full rob");

    assert property (@(posedge clk) disable iff (rst)
        (alu_valid |-> occupied(alu_rob_id)) and (load_valid |-> occupied(load_rob_id)) and
        (store_valid |-> occupied(store_rob_id)) and (branch_valid |-> occupied(branch_rob_id)))
        else $error("completion of an id outside the rob");

    assert property (@(posedge clk) disable iff (rst) count <= (ROB_WIDTH+1)'(NUM_ROB_ENTRY))
        else $error("rob count overflow");

endmodule

/* retire_stage.sv */
`timescale 1ns/10ps

module retire_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             pop,
    input  logic [ooo_pkg::ROB_WIDTH-1:0]    head_id,
    input  ooo_pkg::rob_entry_t              head_entry,
    output logic                             retire_valid,
    output ooo_pkg::retire_t                 retire,
    output logic                             flush,
    output logic                             redirect_valid,
    output logic [ooo_pkg::ADDR_WIDTH-1:0]   redirect_pc
);
    import ooo_pkg::*;

    branch_info_t head_branch;
    logic         mispredict;

    // branch view of the payload is only meaningful for branches
    assign head_branch = head_entry.payload.branch;
    assign mispredict  = pop && head_entry.op_class == OP_BRANCH && head_branch.mispredict;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
            flush        <= 1'b0;
        end else begin
            retire_valid <= pop;
            flush        <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            retire <= '{
                op_class:   head_entry.op_class,
                writes_rd:  head_entry.writes_rd,
                rd_arch:    head_entry.rd_arch,
                rd_phy_new: head_entry.rd_phy_new,
                rd_phy_old: head_entry.rd_phy_old,
                pc:         head_entry.pc,
                rob_id:     head_id,
                payload:    head_entry.payload
            };
            redirect_pc <= head_branch.actual_target;
        end
    end

    assign redirect_valid = flush;

    // nothing younger may retire once the flush reaches the rob
    assert property (@(posedge clk) disable iff (rst)
        flush |-> (retire_valid && retire.op_class == OP_BRANCH) ##1 !retire_valid)
        else $error("flush without a retiring branch, or younger entry retired");

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release away from the active edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
